/* source/mrc_pkg.sv */
package mrc_pkg;

  // --------------------
  // Widths and counts
  localparam int cntl_w        = 2;
  localparam int opt_type_w    = 8;
  localparam int opt_value_w   = 16;
  localparam int opts_per_beat = 3;
  localparam int num_lanes_w   = 6;   // 0 to 32 lanes
  localparam int mgr_id_w      = 8;
  localparam int local_ptr_w   = 32;

  // --------------------
  // Message control codes
  localparam logic [cntl_w-1:0] cntl_mom     = 2'b00;
  localparam logic [cntl_w-1:0] cntl_som     = 2'b01;
  localparam logic [cntl_w-1:0] cntl_eom     = 2'b10;
  localparam logic [cntl_w-1:0] cntl_som_eom = 2'b11;

  // Option type codes
  localparam logic [opt_type_w-1:0] opt_type_none      = 8'h00;
  localparam logic [opt_type_w-1:0] opt_type_num_lanes = 8'h01;
  localparam logic [opt_type_w-1:0] opt_type_memory    = 8'h02;

  // --------------------
  // Descriptor FSM states
  typedef enum logic [2:0] {
    desc_wait,
    desc_extract,
    start_access,
    complete,
    desc_err
  } state_t;

  typedef struct packed {
    logic [opt_type_w-1:0]  opt_type;
    logic [opt_value_w-1:0] value;
  } opt_tuple_t;

  // Tuple 0 sits in the upper bits
  typedef struct packed {
    logic [cntl_w-1:0]                  cntl;
    opt_tuple_t [0:opts_per_beat-1]     opts;
  } mrc_beat_t;

  // Extended tuple, one slot value plus the whole next tuple
  typedef struct packed {
    logic [opt_value_w-1:0] value;
    opt_tuple_t             tuple;
  } ext_view_t;

  // Same 40 bits as a global storage pointer
  typedef struct packed {
    logic [mgr_id_w-1:0]    mgr_id;
    logic [local_ptr_w-1:0] local_ptr;
  } ptr_view_t;

  typedef union packed {
    ext_view_t ext;
    ptr_view_t ptr;
  } ext_tuple_u;

  typedef struct packed {
    logic [num_lanes_w-1:0] num_lanes;
    logic [local_ptr_w-1:0] local_ptr;
  } mrc_access_t;

endpackage

/* source/mrc_desc_buffer.sv */
`timescale 1ns/10ps

module mrc_desc_buffer #(
  parameter int desc_fifo_depth     = 8,
  parameter int desc_fifo_threshold = 5
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               desc_valid,
  input  mrc_pkg::mrc_beat_t desc_beat,
  input  logic               fifo_read,
  output logic               desc_ready,
  output logic               fifo_empty,
  output mrc_pkg::mrc_beat_t fifo_beat
);

  localparam int ptr_w = $clog2(desc_fifo_depth);
  localparam int cnt_w = $clog2(desc_fifo_depth + 1);

  logic               in_valid;
  mrc_pkg::mrc_beat_t in_beat;

  mrc_pkg::mrc_beat_t mem [desc_fifo_depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;

  // --------------------
  // Input register stage
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      in_valid <= 1'b0;
    else
      in_valid <= desc_valid;
  end

  always_ff @(posedge clk)
  begin
    in_beat <= desc_beat;
  end

  // --------------------
  // FIFO storage
  always_ff @(posedge clk)
  begin
    if (in_valid)
      mem[wr_ptr] <= in_beat;
  end

  // Read data lands the cycle after the read
  always_ff @(posedge clk)
  begin
    if (fifo_read)
      fifo_beat <= mem[rd_ptr];
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (in_valid)
        wr_ptr <= (wr_ptr == ptr_w'(desc_fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (fifo_read)
        rd_ptr <= (rd_ptr == ptr_w'(desc_fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({in_valid, fifo_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign fifo_empty = (count == '0);

  // Threshold leaves room for beats already on their way in
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      desc_ready <= 1'b0;
    else
      desc_ready <= (count < cnt_w'(desc_fifo_threshold));
  end

endmodule

/* source/mrc_desc_pipe.sv */
`timescale 1ns/10ps

module mrc_desc_pipe (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fifo_empty,
  input  mrc_pkg::mrc_beat_t fifo_beat,
  input  logic               consume,
  output logic               fifo_read,
  output logic               pipe_valid,
  output mrc_pkg::mrc_beat_t pipe_beat
);

  // FIFO read data register is the first stage
  logic fifo_valid;
  logic fifo_advance;

  // Keep both stages charged
  assign fifo_advance = fifo_valid & (~pipe_valid | consume);
  assign fifo_read    = ~fifo_empty & (~fifo_valid | fifo_advance);

  // --------------------
  // Stage valid flags
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      fifo_valid <= 1'b0;
    else if (fifo_read)
      fifo_valid <= 1'b1;
    else if (fifo_advance)
      fifo_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pipe_valid <= 1'b0;
    else if (fifo_advance)
      pipe_valid <= 1'b1;
    else if (consume)
      pipe_valid <= 1'b0;
  end

  // --------------------
  // Pipe stage data
  always_ff @(posedge clk)
  begin
    if (fifo_advance)
      pipe_beat <= fifo_beat;
  end

endmodule

/* source/mrc_option_extract.sv */
`timescale 1ns/10ps

module mrc_option_extract (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 consume,
  input  logic                 field_clear,
  input  mrc_pkg::mrc_beat_t   pipe_beat,
  output mrc_pkg::mrc_access_t access
);

  logic                            lanes_hit;
  logic [mrc_pkg::num_lanes_w-1:0] lanes_val;
  logic                            ptr_hit;
  mrc_pkg::ext_tuple_u             ptr_word;

  // --------------------
  // Option decode
  always_comb
  begin
    lanes_hit = 1'b0;
    lanes_val = '0;
    ptr_hit   = 1'b0;
    ptr_word  = '0;

    // Walk downward so the lowest slot wins
    for (int i = mrc_pkg::opts_per_beat - 1; i >= 0; i--)
    begin
      if (pipe_beat.opts[i].opt_type == mrc_pkg::opt_type_num_lanes)
      begin
        lanes_hit = 1'b1;
        lanes_val = pipe_beat.opts[i].value[mrc_pkg::num_lanes_w-1:0];
      end
    end

    // Pointer spills into the next tuple, so never from the last slot
    for (int i = mrc_pkg::opts_per_beat - 2; i >= 0; i--)
    begin
      if (pipe_beat.opts[i].opt_type == mrc_pkg::opt_type_memory)
      begin
        ptr_hit            = 1'b1;
        ptr_word.ext.value = pipe_beat.opts[i].value;
        ptr_word.ext.tuple = pipe_beat.opts[i+1];
      end
    end
  end

  // --------------------
  // Captured fields
  always_ff @(posedge clk)
  begin
    if (!rst_n || field_clear)
    begin
      access.num_lanes <= '0;
      access.local_ptr <= '0;
    end
    else if (consume)
    begin
      if (lanes_hit)
        access.num_lanes <= lanes_val;
      // Manager ID bits dropped here
      if (ptr_hit)
        access.local_ptr <= ptr_word.ptr.local_ptr;
    end
  end

endmodule

/* source/mrc_desc_fsm.sv */
`timescale 1ns/10ps

module mrc_desc_fsm (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               pipe_valid,
  input  mrc_pkg::mrc_beat_t pipe_beat,
  output logic               consume,
  output logic               field_clear,
  output logic               access_start,
  output logic               desc_error
);

  mrc_pkg::state_t state;
  mrc_pkg::state_t state_next;
  logic            pipe_som;
  logic            pipe_eom;

  assign pipe_som = (pipe_beat.cntl == mrc_pkg::cntl_som);
  assign pipe_eom = (pipe_beat.cntl == mrc_pkg::cntl_eom);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= mrc_pkg::desc_wait;
    else
      state <= state_next;
  end

  // --------------------
  // Next state
  always_comb
  begin
    state_next = state;
    case (state)
      mrc_pkg::desc_wait:
        if (pipe_valid)
          state_next = pipe_som ? mrc_pkg::desc_extract : mrc_pkg::desc_err;
      mrc_pkg::desc_extract:
        if (pipe_valid && pipe_eom)
          state_next = mrc_pkg::start_access;
      mrc_pkg::start_access:
        state_next = mrc_pkg::complete;
      mrc_pkg::complete:
        state_next = mrc_pkg::desc_wait;
      // Held until reset
      mrc_pkg::desc_err:
        state_next = mrc_pkg::desc_err;
      default:
        state_next = mrc_pkg::desc_wait;
    endcase
  end

  // --------------------
  // Outputs
  // Pipe holds while the request goes out
  assign consume = pipe_valid & ((state == mrc_pkg::desc_wait) ||
                                 (state == mrc_pkg::desc_extract) ||
                                 (state == mrc_pkg::desc_err));

  assign access_start = (state == mrc_pkg::start_access);
  assign field_clear  = (state == mrc_pkg::complete);
  assign desc_error   = (state == mrc_pkg::desc_err);

endmodule

/* source/mrc_cntl.sv */
`timescale 1ns/10ps

module mrc_cntl #(
  parameter int desc_fifo_depth     = 8,
  parameter int desc_fifo_threshold = 5
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 desc_valid,
  input  mrc_pkg::mrc_beat_t   desc_beat,
  output logic                 desc_ready,
  output logic                 access_start,
  output mrc_pkg::mrc_access_t access,
  output logic                 desc_error
);

  // Buffer to pipe
  logic               fifo_empty;
  logic               fifo_read;
  mrc_pkg::mrc_beat_t fifo_beat;

  // Pipe to FSM and extractor
  logic               pipe_valid;
  mrc_pkg::mrc_beat_t pipe_beat;
  logic               consume;
  logic               field_clear;

  // --------------------
  // Input register and descriptor FIFO
  mrc_desc_buffer #(
    .desc_fifo_depth     (desc_fifo_depth),
    .desc_fifo_threshold (desc_fifo_threshold)
  ) desc_buffer_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .desc_valid (desc_valid),
    .desc_beat  (desc_beat),
    .fifo_read  (fifo_read),
    .desc_ready (desc_ready),
    .fifo_empty (fifo_empty),
    .fifo_beat  (fifo_beat)
  );

  mrc_desc_pipe desc_pipe_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_empty (fifo_empty),
    .fifo_beat  (fifo_beat),
    .consume    (consume),
    .fifo_read  (fifo_read),
    .pipe_valid (pipe_valid),
    .pipe_beat  (pipe_beat)
  );

  // --------------------
  // Descriptor processing
  mrc_option_extract option_extract_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .consume     (consume),
    .field_clear (field_clear),
    .pipe_beat   (pipe_beat),
    .access      (access)
  );

  mrc_desc_fsm desc_fsm_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .pipe_valid   (pipe_valid),
    .pipe_beat    (pipe_beat),
    .consume      (consume),
    .field_clear  (field_clear),
    .access_start (access_start),
    .desc_error   (desc_error)
  );

endmodule

/* verification/mrc_cntl_tb_tasks.svh */
`ifndef mrc_cntl_tb_tasks_svh
`define mrc_cntl_tb_tasks_svh

// --------------------
// Sender and request helpers

// Presents one beat in a cycle where desc_ready was seen high
task automatic send_beat(input mrc_pkg::mrc_beat_t beat);
  int waited;
  waited = 0;
  @(negedge clk);
  while (!desc_ready && waited < ready_timeout)
  begin
    @(posedge clk);
    desc_valid <= 1'b0;
    @(negedge clk);
    waited++;
  end
  if (!desc_ready)
  begin
    $display("Timed out waiting for desc_ready before sending a beat");
    error_count++;
  end
  else
  begin
    @(posedge clk);
    desc_valid <= 1'b1;
    desc_beat  <= beat;
  end
endtask

task automatic send_desc(input bit expect_request);
  mrc_pkg::mrc_access_t acc;
  acc = '0;
  foreach (desc_q[i])
  begin
    acc = apply_options(acc, desc_q[i]);
    send_beat(desc_q[i]);
  end
  if (expect_request)
    exp_q.push_back(acc);
  desc_q.delete();
endtask

task automatic queue_random_desc(input int n_beats);
  mrc_pkg::mrc_beat_t b;
  int                 k;
  int                 s;
  for (k = 0; k < n_beats; k++)
  begin
    b.cntl = (k == 0) ? c_som : ((k == n_beats - 1) ? c_eom : c_mom);
    for (s = 0; s < 3; s++)
    begin
      case ($urandom_range(0, 3))
        0:       b.opts[s].opt_type = t_none;
        1:       b.opts[s].opt_type = t_lanes;
        2:       b.opts[s].opt_type = t_mem;
        default: b.opts[s].opt_type = 8'h80 | 8'($urandom_range(0, 127));
      endcase
      if (b.opts[s].opt_type == t_lanes)
        b.opts[s].value = 16'($urandom_range(0, 32));
      else
        b.opts[s].value = 16'($urandom);
    end
    desc_q.push_back(b);
  end
endtask

// Stops the sender, then matches requests against the model in order
task automatic check_requests();
  int                   waited;
  mrc_pkg::mrc_access_t got;
  mrc_pkg::mrc_access_t exp;
  waited = 0;
  @(posedge clk);
  desc_valid <= 1'b0;
  while (access_q.size() < exp_q.size() && waited < req_timeout)
  begin
    @(negedge clk);
    waited++;
  end
  assert (access_q.size() == exp_q.size())
  else
  begin
    $display("%0d access requests arrived where %0d were expected", access_q.size(),
             exp_q.size());
    error_count++;
  end
  while (access_q.size() > 0 && exp_q.size() > 0)
  begin
    got = access_q.pop_front();
    exp = exp_q.pop_front();
    check_value("access.num_lanes", 32'(got.num_lanes), 32'(exp.num_lanes));
    check_value("access.local_ptr", got.local_ptr, exp.local_ptr);
  end
  access_q.delete();
  exp_q.delete();
endtask

// --------------------
// Directed tests

task automatic check_reset_behavior();
  int errs;
  errs = error_count;
  apply_reset(1'b1);
  report_test("reset_state", errs);
endtask

task automatic single_descriptor();
  int errs;
  errs = error_count;
  desc_q.push_back(make_beat(c_som, t_none, 16'h0, t_lanes, 16'd12, t_none, 16'h0));
  desc_q.push_back(make_beat(c_mom, t_none, 16'h5555, 8'h40, 16'h0f0f, t_none, 16'h0));
  desc_q.push_back(make_beat(c_eom, t_mem, 16'ha5c3, 8'h7e, 16'h1234, t_none, 16'h0));
  send_desc(1'b1);
  check_requests();
  report_test("single_descriptor", errs);
endtask

task automatic field_rules();
  int errs;
  errs = error_count;
  // Two lane counts, a pointer in the last slot, and a pointer from slot 1
  desc_q.push_back(make_beat(c_som, t_lanes, 16'd5, t_none, 16'h0, t_lanes, 16'd20));
  desc_q.push_back(make_beat(c_mom, t_none, 16'h0, t_none, 16'h0, t_mem, 16'h1111));
  desc_q.push_back(make_beat(c_eom, t_none, 16'h0, t_mem, 16'hbeef, 8'h3c, 16'h9876));
  send_desc(1'b1);
  // No options, so both fields read back as zero
  desc_q.push_back(make_beat(c_som, t_none, 16'h0, t_none, 16'h0, t_none, 16'h0));
  desc_q.push_back(make_beat(c_eom, t_none, 16'h0, t_none, 16'h0, t_none, 16'h0));
  send_desc(1'b1);
  check_requests();
  report_test("field_rules", errs);
endtask

task automatic back_to_back_stream();
  int errs;
  int d;
  errs = error_count;
  for (d = 0; d < 6; d++)
  begin
    queue_random_desc($urandom_range(2, 4));
    send_desc(1'b1);
  end
  check_requests();
  report_test("back_to_back", errs);
endtask

task automatic backpressure_burst();
  int errs;
  int d;
  errs          = error_count;
  ready_dropped = 1'b0;
  for (d = 0; d < 10; d++)
  begin
    queue_random_desc(5);
    send_desc(1'b1);
  end
  check_requests();
  assert (ready_dropped)
  else
  begin
    $display("desc_ready never dropped during the burst");
    error_count++;
  end
  report_test("back_pressure", errs);
endtask

task automatic error_latch();
  int errs;
  int waited;
  int i;
  errs = error_count;
  desc_q.push_back(make_beat(c_mom, t_lanes, 16'd9, t_none, 16'h0, t_none, 16'h0));
  desc_q.push_back(make_beat(c_eom, t_none, 16'h0, t_none, 16'h0, t_none, 16'h0));
  send_desc(1'b0);
  desc_q.push_back(make_beat(c_som, t_lanes, 16'd3, t_none, 16'h0, t_none, 16'h0));
  desc_q.push_back(make_beat(c_eom, t_mem, 16'h00aa, 8'h11, 16'h2233, t_none, 16'h0));
  send_desc(1'b0);
  @(posedge clk);
  desc_valid <= 1'b0;
  waited = 0;
  while (!desc_error && waited < req_timeout)
  begin
    @(negedge clk);
    waited++;
  end
  assert (desc_error)
  else
  begin
    $display("desc_error did not rise after a descriptor without a start beat");
    error_count++;
  end
  for (i = 0; i < 40; i++)
  begin
    @(negedge clk);
    check_value("desc_error", desc_error, 1'b1);
    check_value("desc_ready", desc_ready, 1'b1);
  end
  assert (access_q.size() == 0)
  else
  begin
    $display("access_start pulsed although the error was latched");
    error_count++;
  end
  // Reset clears the error and requests flow again
  apply_reset(1'b0);
  check_value("desc_error", desc_error, 1'b0);
  desc_q.push_back(make_beat(c_som, t_lanes, 16'd7, t_none, 16'h0, t_none, 16'h0));
  desc_q.push_back(make_beat(c_eom, t_mem, 16'h4321, 8'h55, 16'h6789, t_none, 16'h0));
  send_desc(1'b1);
  check_requests();
  report_test("error_latch", errs);
endtask

`endif

/* verification/mrc_cntl_tb.sv */
`timescale 1ns/10ps

module mrc_cntl_tb;

  localparam int ready_timeout = 200;
  localparam int req_timeout   = 400;

  // Short names for the codes used in the tests
  localparam logic [1:0] c_som   = mrc_pkg::cntl_som;
  localparam logic [1:0] c_mom   = mrc_pkg::cntl_mom;
  localparam logic [1:0] c_eom   = mrc_pkg::cntl_eom;
  localparam logic [7:0] t_none  = mrc_pkg::opt_type_none;
  localparam logic [7:0] t_lanes = mrc_pkg::opt_type_num_lanes;
  localparam logic [7:0] t_mem   = mrc_pkg::opt_type_memory;

  logic                 clk;
  logic                 rst_n;
  logic                 desc_valid;
  mrc_pkg::mrc_beat_t   desc_beat;
  logic                 desc_ready;
  logic                 access_start;
  mrc_pkg::mrc_access_t access;
  logic                 desc_error;

  int error_count;
  int tests_run;
  int tests_failed;
  bit ready_dropped;

  // Seen requests, predicted requests, beats of the descriptor being built
  mrc_pkg::mrc_access_t access_q[$];
  mrc_pkg::mrc_access_t exp_q[$];
  mrc_pkg::mrc_beat_t   desc_q[$];

  mrc_cntl #(
    .desc_fifo_depth     (8),
    .desc_fifo_threshold (5)
  ) mrc_cntl_inst (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // Monitor on the falling edge
  always @(negedge clk)
  begin
    if (rst_n && access_start)
      access_q.push_back(access);
    if (rst_n && !desc_ready)
      ready_dropped = 1'b1;
  end

  function automatic mrc_pkg::mrc_beat_t make_beat(
    input logic [1:0]  cntl,
    input logic [7:0]  t0,
    input logic [15:0] v0,
    input logic [7:0]  t1,
    input logic [15:0] v1,
    input logic [7:0]  t2,
    input logic [15:0] v2
  );
    mrc_pkg::mrc_beat_t b;
    b.cntl    = cntl;
    b.opts[0] = {t0, v0};
    b.opts[1] = {t1, v1};
    b.opts[2] = {t2, v2};
    return b;
  endfunction

  // Lowest slot wins, and a pointer never starts in the last slot
  function automatic mrc_pkg::mrc_access_t apply_options(
    input mrc_pkg::mrc_access_t acc,
    input mrc_pkg::mrc_beat_t   b
  );
    logic [39:0] global_ptr;
    bit          lanes_found;
    int          s;
    global_ptr  = '0;
    lanes_found = 1'b0;
    for (s = 0; s < 3; s++)
    begin
      if (!lanes_found && b.opts[s].opt_type == t_lanes)
      begin
        acc.num_lanes = b.opts[s].value[5:0];
        lanes_found   = 1'b1;
      end
    end
    if (b.opts[0].opt_type == t_mem)
      global_ptr = {b.opts[0].value, b.opts[1]};
    else if (b.opts[1].opt_type == t_mem)
      global_ptr = {b.opts[1].value, b.opts[2]};
    // Manager ID sits above the local pointer
    if (b.opts[0].opt_type == t_mem || b.opts[1].opt_type == t_mem)
      acc.local_ptr = global_ptr[31:0];
    return acc;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before)
      $display("%s: passed", name);
    else
    begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, error_count - errs_before);
    end
  endtask

  task automatic apply_reset(input bit check);
    int i;
    int waited;
    for (i = 0; i < 10; i++)
    begin
      @(posedge clk);
      rst_n      <= 1'b0;
      desc_valid <= 1'b0;
      @(negedge clk);
      if (check && i > 0)
      begin
        check_value("access_start", access_start, 1'b0);
        check_value("desc_error", desc_error, 1'b0);
      end
    end
    @(posedge clk);
    rst_n <= 1'b1;
    access_q.delete();
    exp_q.delete();
    desc_q.delete();
    @(negedge clk);
    if (check)
    begin
      check_value("access_start", access_start, 1'b0);
      check_value("desc_error", desc_error, 1'b0);
    end
    waited = 0;
    while (!desc_ready && waited < 2)
    begin
      @(negedge clk);
      waited++;
    end
    if (check)
      check_value("desc_ready", desc_ready, 1'b1);
  endtask

  `include "mrc_cntl_tb_tasks.svh"

  // --------------------
  // Test sequence
  initial
  begin
    void'($urandom(32'h299b));
    rst_n        = 1'b0;
    desc_valid   = 1'b0;
    desc_beat    = '0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    check_reset_behavior();
    single_descriptor();
    field_rules();
    back_to_back_stream();
    backpressure_burst();
    error_latch();
    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+verification
source/mrc_pkg.sv
source/mrc_desc_buffer.sv
source/mrc_desc_pipe.sv
source/mrc_option_extract.sv
source/mrc_desc_fsm.sv
source/mrc_cntl.sv
verification/mrc_cntl_tb.sv

/* Bender.yml */
package:
  name: mrc_cntl

sources:
  - source/mrc_pkg.sv
  - source/mrc_desc_buffer.sv
  - source/mrc_desc_pipe.sv
  - source/mrc_option_extract.sv
  - source/mrc_desc_fsm.sv
  - source/mrc_cntl.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/mrc_cntl_tb.sv
